//--- build.f
+incdir+hdl
hdl/lz77_pkg.sv
hdl/lz77_fifo.sv
hdl/lz77_wb_ingress.sv
hdl/lz77_window.sv
hdl/lz77_matcher.sv
hdl/lz77_top.sv
sim/tb_lz77_chk.sv
sim/tb_lz77.sv

//--- hdl/lz77_fifo.sv
// synchronous show-ahead fifo with a type parameter for its payload
// serves as the input byte buffer and as the token buffer
`include "lz77_macros.svh"

module lz77_fifo
  import lz77_pkg::*;
#(
  parameter type payload_t = lz_byte_t,
  parameter int  DEPTH     = `LZ_IN_DEPTH
) (
  input  logic     clk,
  input  logic     rstn,
  input  logic     push_i,
  input  payload_t push_dat_i,
  output logic     full_o,
  input  logic     pop_i,
  output payload_t pop_dat_o,
  output logic     empty_o
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t        mem_r [DEPTH];
  logic [AW-1:0]   wr_ptr_r;
  logic [AW-1:0]   rd_ptr_r;
  logic [CW-1:0]   cnt_r;
  logic            wr_en_w;
  logic            rd_en_w;

  assign full_o  = (cnt_r == CW'(DEPTH));
  assign empty_o = (cnt_r == '0);

  // requests against a full or empty fifo are dropped
  assign wr_en_w = push_i && !full_o;
  assign rd_en_w = pop_i && !empty_o;

  always_ff @(posedge clk) begin
    if (wr_en_w) begin
      mem_r[wr_ptr_r] <= push_dat_i;
    end
  end

  assign pop_dat_o = mem_r[rd_ptr_r];

  // pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      cnt_r    <= '0;
    end else begin
      if (wr_en_w) begin
        wr_ptr_r <= (wr_ptr_r == AW'(DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (rd_en_w) begin
        rd_ptr_r <= (rd_ptr_r == AW'(DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      cnt_r <= cnt_r + CW'(wr_en_w) - CW'(rd_en_w);
    end
  end

endmodule

//--- hdl/lz77_macros.svh
// sizes of the lz77 window, lookahead and match lengths
// include wherever a size or a field width is needed
`ifndef LZ77_MACROS_SVH
`define LZ77_MACROS_SVH

// ---------------------------------------------------------------------------
// search geometry
// ---------------------------------------------------------------------------

// history bytes kept per block
`define LZ_WIN_SIZE 16

// longest match, also the lookahead depth
`define LZ_LEN_MAX 8

// shorter results go out as literals
`define LZ_LEN_MIN 3

// ---------------------------------------------------------------------------
// field widths and buffering
// ---------------------------------------------------------------------------

// distance 1..16
`define LZ_DST_WD 5

// length 0..8
`define LZ_LEN_WD 4

`define LZ_IN_DEPTH 8
`define LZ_TOK_DEPTH 4

`endif

//--- hdl/lz77_matcher.sv
// lz77 match search over the window and a lookahead of up to LZ_LEN_MAX bytes
// pops input bytes, pushes one token per match and feeds the window
`include "lz77_macros.svh"

module lz77_matcher
  import lz77_pkg::*;
(
  input  logic                        clk,
  input  logic                        rstn,
  // input fifo read side
  input  lz_in_t                      in_dat_i,
  input  logic                        in_empty_i,
  output logic                        in_pop_o,
  // token fifo write side
  output lz_token_t                   tok_o,
  output logic                        tok_push_o,
  input  logic                        tok_full_i,
  // window
  input  lz_byte_t [`LZ_WIN_SIZE-1:0] win_i,
  input  logic     [`LZ_DST_WD-1:0]   win_len_i,
  output logic                        win_shift_o,
  output lz_byte_t                    win_dat_o,
  output logic                        win_clear_o
);

  typedef enum logic [1:0] {FILL, SEARCH, EMIT, CONSUME} state_t;

  state_t                        state_r;
  lz_byte_t [`LZ_LEN_MAX-1:0]    la_r;
  logic     [`LZ_LEN_WD-1:0]     la_cnt_r;
  logic                          la_last_r;
  logic     [`LZ_WIN_SIZE-1:0]   mat_r;
  logic     [`LZ_WIN_SIZE-1:0]   mat_w;
  logic     [`LZ_LEN_WD-1:0]     step_r;
  logic     [`LZ_LEN_WD-1:0]     best_len_r;
  logic     [`LZ_DST_WD-1:0]     best_dst_r;
  logic     [`LZ_DST_WD-1:0]     near_w;
  logic     [`LZ_LEN_WD-1:0]     cns_cnt_r;
  logic     [`LZ_LEN_WD-1:0]     use_len_w;
  logic                          la_full_w;
  logic                          search_done_w;
  logic                          lit_w;
  logic                          blk_end_w;

  // ---------------------------------------------------------------------------
  // match flags
  // ---------------------------------------------------------------------------

  // flag i is distance i+1; step_r is the lookahead byte compared now.
  // a distance below the compared length would reach into the lookahead
  always_comb begin
    mat_w = '0;
    for (int i = 0; i < `LZ_WIN_SIZE; i++) begin
      if (i >= int'(step_r) && i < int'(win_len_i)) begin
        mat_w[i] = mat_r[i] && (win_i[i - int'(step_r)] == la_r[step_r]);
      end
    end
  end

  // nearest surviving distance
  always_comb begin
    near_w = '0;
    for (int i = `LZ_WIN_SIZE - 1; i >= 0; i--) begin
      if (mat_w[i]) begin
        near_w = `LZ_DST_WD'(i + 1);
      end
    end
  end

  // stop when no candidate is left or the lookahead is used up
  assign search_done_w = !(|mat_w) || (step_r + 1'b1 == la_cnt_r);

  // ---------------------------------------------------------------------------
  // token forming
  // ---------------------------------------------------------------------------

  assign lit_w     = (best_len_r < `LZ_LEN_WD'(`LZ_LEN_MIN));
  assign use_len_w = lit_w ? `LZ_LEN_WD'(1) : best_len_r;

  always_comb begin
    tok_o     = '0;
    tok_o.lit = lit_w;
    if (lit_w) begin
      tok_o.lit_dat = la_r[0];
    end else begin
      tok_o.len = best_len_r;
      tok_o.dst = best_dst_r;
    end
    // token that uses the final byte of the block
    tok_o.last = la_last_r && (use_len_w == la_cnt_r);
  end

  assign tok_push_o = (state_r == EMIT) && !tok_full_i;

  // ---------------------------------------------------------------------------
  // lookahead and window handshakes
  // ---------------------------------------------------------------------------

  assign la_full_w = (la_cnt_r == `LZ_LEN_WD'(`LZ_LEN_MAX));

  // bytes of the next block wait until this one is done
  assign in_pop_o = (state_r == FILL) && !la_full_w && !la_last_r && !in_empty_i;

  assign blk_end_w   = (state_r == CONSUME) && la_last_r && (la_cnt_r == 1'b1);
  assign win_clear_o = blk_end_w;
  assign win_shift_o = (state_r == CONSUME) && !blk_end_w;
  assign win_dat_o   = la_r[0];

  // load at the tail, compact from the head
  always_ff @(posedge clk) begin
    if (in_pop_o) begin
      la_r[la_cnt_r] <= in_dat_i.dat;
    end else if (state_r == CONSUME) begin
      for (int i = 0; i < `LZ_LEN_MAX - 1; i++) begin
        la_r[i] <= la_r[i+1];
      end
    end
  end

  // ---------------------------------------------------------------------------
  // fsm
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_r    <= FILL;
      la_cnt_r   <= '0;
      la_last_r  <= 1'b0;
      mat_r      <= '0;
      step_r     <= '0;
      best_len_r <= '0;
      best_dst_r <= '0;
      cns_cnt_r  <= '0;
    end else begin
      case (state_r)
        FILL: begin
          if (la_full_w || la_last_r) begin
            state_r    <= SEARCH;
            mat_r      <= '1;
            step_r     <= '0;
            best_len_r <= `LZ_LEN_WD'(1);
            best_dst_r <= '0;
          end else if (in_pop_o) begin
            la_cnt_r  <= la_cnt_r + 1'b1;
            la_last_r <= in_dat_i.last;
          end
        end
        SEARCH: begin
          mat_r  <= mat_w;
          step_r <= step_r + 1'b1;
          if (|mat_w) begin
            best_len_r <= step_r + 1'b1;
            best_dst_r <= near_w;
          end
          if (search_done_w) begin
            state_r <= EMIT;
          end
        end
        // decision cycle, held while the token fifo is full
        EMIT: begin
          if (tok_push_o) begin
            cns_cnt_r <= use_len_w;
            state_r   <= CONSUME;
          end
        end
        CONSUME: begin
          la_cnt_r  <= la_cnt_r - 1'b1;
          cns_cnt_r <= cns_cnt_r - 1'b1;
          if (blk_end_w) begin
            la_last_r <= 1'b0;
          end
          if (cns_cnt_r == 1'b1) begin
            state_r <= FILL;
          end
        end
        default: state_r <= FILL;
      endcase
    end
  end

endmodule

//--- hdl/lz77_pkg.sv
// shared types of the lz77 compressor
// data bytes, fifo entries, output tokens and the wishbone bus
`include "lz77_macros.svh"

package lz77_pkg;

  // one data byte
  typedef logic [7:0] lz_byte_t;

  // input fifo entry
  typedef struct packed {
    lz_byte_t dat;
    // last byte of the block
    logic     last;
  } lz_in_t;

  // output token, literal or (length, distance) pair
  typedef struct packed {
    logic                  lit;
    lz_byte_t              lit_dat;
    // zero for a literal
    logic [`LZ_LEN_WD-1:0] len;
    logic [`LZ_DST_WD-1:0] dst;
    logic                  last;
  } lz_token_t;

  // wishbone classic request, master to slave
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    // 0 ordinary byte, 1 last byte of block
    logic     adr;
    lz_byte_t dat;
  } lz_wb_req_t;

  // wishbone classic response
  typedef struct packed {
    logic ack;
  } lz_wb_rsp_t;

endpackage

//--- hdl/lz77_top.sv
// lz77 compressor top, wishbone bytes in and a valid/ready token stream out
// ingress, input fifo, matcher with window, token fifo
`include "lz77_macros.svh"

module lz77_top
  import lz77_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  // wishbone slave
  input  lz_wb_req_t wb_req_i,
  output lz_wb_rsp_t wb_rsp_o,
  // token stream
  output lz_token_t  tok_o,
  output logic       tok_valid_o,
  input  logic       tok_ready_i
);

  lz_in_t                      in_push_dat;
  logic                        in_push;
  logic                        in_full;
  lz_in_t                      in_pop_dat;
  logic                        in_pop;
  logic                        in_empty;
  lz_token_t                   tok_push_dat;
  logic                        tok_push;
  logic                        tok_full;
  logic                        tok_empty;
  lz_byte_t [`LZ_WIN_SIZE-1:0] win;
  logic     [`LZ_DST_WD-1:0]   win_len;
  logic                        win_shift;
  lz_byte_t                    win_dat;
  logic                        win_clear;

  // ---------------------------------------------------------------------------
  // input side
  // ---------------------------------------------------------------------------

  lz77_wb_ingress u_ingress (
    .clk        (clk),
    .rstn       (rstn),
    .wb_req_i   (wb_req_i),
    .wb_rsp_o   (wb_rsp_o),
    .push_o     (in_push),
    .push_dat_o (in_push_dat),
    .full_i     (in_full)
  );

  lz77_fifo #(
    .payload_t (lz_in_t),
    .DEPTH     (`LZ_IN_DEPTH)
  ) u_in_fifo (
    .clk        (clk),
    .rstn       (rstn),
    .push_i     (in_push),
    .push_dat_i (in_push_dat),
    .full_o     (in_full),
    .pop_i      (in_pop),
    .pop_dat_o  (in_pop_dat),
    .empty_o    (in_empty)
  );

  // ---------------------------------------------------------------------------
  // search
  // ---------------------------------------------------------------------------

  lz77_window u_window (
    .clk         (clk),
    .rstn        (rstn),
    .shift_i     (win_shift),
    .shift_dat_i (win_dat),
    .clear_i     (win_clear),
    .win_o       (win),
    .win_len_o   (win_len)
  );

  lz77_matcher u_matcher (
    .clk         (clk),
    .rstn        (rstn),
    .in_dat_i    (in_pop_dat),
    .in_empty_i  (in_empty),
    .in_pop_o    (in_pop),
    .tok_o       (tok_push_dat),
    .tok_push_o  (tok_push),
    .tok_full_i  (tok_full),
    .win_i       (win),
    .win_len_i   (win_len),
    .win_shift_o (win_shift),
    .win_dat_o   (win_dat),
    .win_clear_o (win_clear)
  );

  // ---------------------------------------------------------------------------
  // output side
  // ---------------------------------------------------------------------------

  // fifo head is the stream; a transfer pops it
  lz77_fifo #(
    .payload_t (lz_token_t),
    .DEPTH     (`LZ_TOK_DEPTH)
  ) u_tok_fifo (
    .clk        (clk),
    .rstn       (rstn),
    .push_i     (tok_push),
    .push_dat_i (tok_push_dat),
    .full_o     (tok_full),
    .pop_i      (tok_valid_o && tok_ready_i),
    .pop_dat_o  (tok_o),
    .empty_o    (tok_empty)
  );

  assign tok_valid_o = !tok_empty;

endmodule

//--- hdl/lz77_wb_ingress.sv
// wishbone classic write slave in front of the input fifo
// address 0 takes an ordinary byte, address 1 the last byte of a block
`include "lz77_macros.svh"

module lz77_wb_ingress
  import lz77_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  // wishbone slave
  input  lz_wb_req_t wb_req_i,
  output lz_wb_rsp_t wb_rsp_o,
  // input fifo write side
  output logic       push_o,
  output lz_in_t     push_dat_o,
  input  logic       full_i
);

  logic ack_r;
  logic wr_req_w;
  logic accept_w;

  // ---------------------------------------------------------------------------
  // request decode
  // ---------------------------------------------------------------------------

  assign wr_req_w = wb_req_i.cyc && wb_req_i.stb && wb_req_i.we;

  // one acceptance per write; the cycle with ack high is the
  // master's last cycle of that write, so it is not taken again
  assign accept_w = wr_req_w && !ack_r && !full_i;

  // ---------------------------------------------------------------------------
  // ack and fifo push
  // ---------------------------------------------------------------------------

  // single cycle ack, one cycle after the request
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ack_r <= 1'b0;
    end else begin
      ack_r <= accept_w;
    end
  end

  assign wb_rsp_o.ack = ack_r;

  // entry lands in the fifo on the edge that raises ack
  assign push_o = accept_w;

  always_comb begin
    push_dat_o      = '0;
    push_dat_o.dat  = wb_req_i.dat;
    // address bit marks the end of the block
    push_dat_o.last = wb_req_i.adr;
  end

  // while the fifo is full the write simply waits,
  // which is the back-pressure path toward the master

endmodule

//--- hdl/lz77_window.sv
// sliding history window of the current block
// index 0 holds distance 1; clear empties it between blocks
`include "lz77_macros.svh"

module lz77_window
  import lz77_pkg::*;
(
  input  logic                          clk,
  input  logic                          rstn,
  // newest byte in
  input  logic                          shift_i,
  input  lz_byte_t                      shift_dat_i,
  input  logic                          clear_i,
  // history out
  output lz_byte_t [`LZ_WIN_SIZE-1:0]   win_o,
  output logic     [`LZ_DST_WD-1:0]     win_len_o
);

  lz_byte_t [`LZ_WIN_SIZE-1:0] win_r;
  logic     [`LZ_DST_WD-1:0]   len_r;
  logic                        len_sat_w;

  // ---------------------------------------------------------------------------
  // history bytes
  // ---------------------------------------------------------------------------

  // newest byte enters at distance 1, older bytes move one place out
  always_ff @(posedge clk) begin
    if (shift_i && !clear_i) begin
      win_r[0] <= shift_dat_i;
      for (int i = 1; i < `LZ_WIN_SIZE; i++) begin
        win_r[i] <= win_r[i-1];
      end
    end
  end

  // ---------------------------------------------------------------------------
  // fill count
  // ---------------------------------------------------------------------------

  assign len_sat_w = (len_r == `LZ_DST_WD'(`LZ_WIN_SIZE));

  // clear wins over a shift in the same cycle
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      len_r <= '0;
    end else if (clear_i) begin
      len_r <= '0;
    end else if (shift_i && !len_sat_w) begin
      len_r <= len_r + 1'b1;
    end
  end

  assign win_o     = win_r;
  assign win_len_o = len_r;

endmodule

//--- sim/tb_lz77.sv
// directed tests for the lz77 compressor top
// writes blocks over wishbone, collects tokens and compares them with a model
`include "lz77_macros.svh"

module tb_lz77;
  import lz77_pkg::*;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 2000;

  logic       clk;
  logic       rstn;
  lz_wb_req_t wb_req;
  lz_wb_rsp_t wb_rsp;
  lz_token_t  tok;
  logic       tok_valid;
  logic       tok_ready;

  lz_byte_t   blk_q[$];
  lz_token_t  exp_q[$];
  lz_token_t  got_q[$];
  lz_token_t  first_q[$];
  bit         ready_rand;
  int         errors;
  int         tests;

  lz77_top dut (
    .clk         (clk),
    .rstn        (rstn),
    .wb_req_i    (wb_req),
    .wb_rsp_o    (wb_rsp),
    .tok_o       (tok),
    .tok_valid_o (tok_valid),
    .tok_ready_i (tok_ready)
  );

  bind lz77_top tb_lz77_chk u_chk (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // random stalls on the token stream when enabled
  always @(posedge clk) begin
    if (ready_rand) begin
      tok_ready <= ($urandom_range(0, 3) != 0);
    end else begin
      tok_ready <= 1'b1;
    end
  end

  // ---------------------------------------------------------------------------
  // reference model of the token rule
  // ---------------------------------------------------------------------------

  function automatic bit seq_match(int pos, int d, int l);
    for (int k = 0; k < l; k++) begin
      if (blk_q[pos - d + k] != blk_q[pos + k]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic build_expected();
    int        pos;
    int        fill;
    int        maxl;
    int        best_l;
    int        best_d;
    int        found_d;
    int        adv;
    lz_token_t t;
    exp_q.delete();
    pos = 0;
    while (pos < blk_q.size()) begin
      fill   = (pos < `LZ_WIN_SIZE) ? pos : `LZ_WIN_SIZE;
      maxl   = blk_q.size() - pos;
      maxl   = (maxl < `LZ_LEN_MAX) ? maxl : `LZ_LEN_MAX;
      best_l = 0;
      best_d = 0;
      // distance must cover the length, nearest one wins
      for (int l = 1; l <= maxl; l++) begin
        found_d = 0;
        for (int d = l; d <= fill; d++) begin
          if (found_d == 0 && seq_match(pos, d, l)) begin
            found_d = d;
          end
        end
        if (found_d != 0) begin
          best_l = l;
          best_d = found_d;
        end
      end
      t = '0;
      if (best_l < `LZ_LEN_MIN) begin
        t.lit     = 1'b1;
        t.lit_dat = blk_q[pos];
        adv       = 1;
      end else begin
        t.len = `LZ_LEN_WD'(best_l);
        t.dst = `LZ_DST_WD'(best_d);
        adv   = best_l;
      end
      t.last = (pos + adv == blk_q.size());
      exp_q.push_back(t);
      pos += adv;
    end
  endtask

  // ---------------------------------------------------------------------------
  // bus drivers and token collector
  // ---------------------------------------------------------------------------

  task automatic abort_run(string why);
    $display("%s", why);
    $display("%0d tests run, %0d errors", tests, errors + 1);
    $display("TEST FAIL");
    $finish;
  endtask

  task automatic write_byte(lz_byte_t dat, logic last);
    lz_wb_req_t req;
    int         n;
    req     = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = 1'b1;
    req.adr = last;
    req.dat = dat;
    @(posedge clk);
    wb_req <= req;
    n = 0;
    @(posedge clk);
    while (!wb_rsp.ack && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (wb_rsp.ack) begin
      wb_req <= '0;
    end else begin
      abort_run("timeout: wishbone write was never acknowledged");
    end
  endtask

  task automatic send_block(int gap_max);
    for (int i = 0; i < blk_q.size(); i++) begin
      repeat ($urandom_range(0, gap_max)) @(posedge clk);
      write_byte(blk_q[i], i == blk_q.size() - 1);
    end
  endtask

  // idle counter restarts with every token
  task automatic collect_block();
    int n;
    bit done;
    got_q.delete();
    n    = 0;
    done = 1'b0;
    while (!done && n < TIMEOUT) begin
      @(posedge clk);
      if (tok_valid && tok_ready) begin
        got_q.push_back(tok);
        done = tok.last;
        n    = 0;
      end else begin
        n++;
      end
    end
    if (!done) begin
      abort_run("timeout: last token of the block never arrived");
    end
  endtask

  // ---------------------------------------------------------------------------
  // comparison
  // ---------------------------------------------------------------------------

  task automatic check_field(string sig, int idx, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR %s[%0d]: got %0h expected %0h", sig, idx, got, exp);
      errors++;
    end
  endtask

  task automatic check_block();
    int n;
    check_field("tok_o count", 0, got_q.size(), exp_q.size());
    n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
    for (int i = 0; i < n; i++) begin
      check_field("tok_o.lit", i, got_q[i].lit, exp_q[i].lit);
      check_field("tok_o.lit_dat", i, got_q[i].lit_dat, exp_q[i].lit_dat);
      check_field("tok_o.len", i, got_q[i].len, exp_q[i].len);
      check_field("tok_o.dst", i, got_q[i].dst, exp_q[i].dst);
      check_field("tok_o.last", i, got_q[i].last, exp_q[i].last);
    end
  endtask

  task automatic run_block(int gap_max);
    build_expected();
    fork
      send_block(gap_max);
      collect_block();
    join
    check_block();
  endtask

  task automatic report_test(string name, int err_before);
    tests++;
    $display("%-14s %0d tokens  %s", name, got_q.size(),
             (errors == err_before) ? "ok" : "mismatch");
  endtask

  // ---------------------------------------------------------------------------
  // tests
  // ---------------------------------------------------------------------------

  task automatic test_literals();
    int e0;
    e0 = errors;
    blk_q.delete();
    for (int i = 0; i < 12; i++) begin
      blk_q.push_back(lz_byte_t'(8'h10 + i * 5));
    end
    run_block(0);
    report_test("literals", e0);
  endtask

  task automatic test_period3();
    int e0;
    e0 = errors;
    blk_q.delete();
    for (int i = 0; i < 21; i++) begin
      blk_q.push_back(lz_byte_t'(8'h61 + i % 3));
    end
    run_block(0);
    report_test("period3", e0);
  endtask

  task automatic test_run();
    int e0;
    e0 = errors;
    blk_q.delete();
    repeat (20) blk_q.push_back(8'h5a);
    run_block(0);
    report_test("run", e0);
  endtask

  // same tokens twice means the window starts empty each block
  task automatic test_block_repeat();
    int e0;
    e0 = errors;
    blk_q.delete();
    for (int i = 0; i < 20; i++) begin
      blk_q.push_back(lz_byte_t'(8'h30 + (i * 7) % 5));
    end
    run_block(1);
    first_q = got_q;
    run_block(1);
    check_field("tok_o count repeat", 0, got_q.size(), first_q.size());
    for (int i = 0; i < got_q.size() && i < first_q.size(); i++) begin
      check_field("tok_o repeat", i, got_q[i], first_q[i]);
    end
    report_test("block_repeat", e0);
  endtask

  task automatic test_random();
    int e0;
    int sum;
    e0 = errors;
    ready_rand <= 1'b1;
    for (int b = 0; b < 4; b++) begin
      blk_q.delete();
      repeat ($urandom_range(1, 40)) blk_q.push_back(lz_byte_t'(8'h61 + $urandom_range(0, 3)));
      run_block(3);
      sum = 0;
      foreach (got_q[i]) begin
        sum += got_q[i].lit ? 1 : int'(got_q[i].len);
      end
      check_field("length sum", b, sum, blk_q.size());
    end
    ready_rand <= 1'b0;
    report_test("random", e0);
  endtask

  initial begin
    rstn       = 1'b0;
    wb_req     = '0;
    tok_ready  = 1'b0;
    ready_rand = 1'b0;
    errors     = 0;
    tests      = 0;
    void'($urandom(32'h65ba4f85));
    repeat (2) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);
    test_literals();
    test_period3();
    test_run();
    test_block_repeat();
    test_random();
    // protocol assertion failures from the bound checker
    errors += dut.u_chk.fail_cnt;
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- sim/tb_lz77_chk.sv
// protocol checks on the lz77 top-level ports
// bound to lz77_top from the testbench
`include "lz77_macros.svh"

module tb_lz77_chk
  import lz77_pkg::*;
(
  input logic       clk,
  input logic       rstn,
  input lz_wb_req_t wb_req_i,
  input lz_wb_rsp_t wb_rsp_o,
  input lz_token_t  tok_o,
  input logic       tok_valid_o,
  input logic       tok_ready_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // failed assertions so far
  int fail_cnt = 0;

  // ack only answers a live wishbone cycle
  ack_in_cycle: assert property (@(posedge clk) disable iff (!rstn)
    wb_rsp_o.ack |-> (wb_req_i.cyc && wb_req_i.stb))
    else begin
      $error("ack high outside a wishbone cycle");
      fail_cnt++;
    end

  // stalled token holds still
  tok_stable: assert property (@(posedge clk) disable iff (!rstn)
    (tok_valid_o && !tok_ready_i) |=> (tok_valid_o && $stable(tok_o)))
    else begin
      $error("token changed or dropped while stalled");
      fail_cnt++;
    end

  // pair lengths stay in range
  pair_len: assert property (@(posedge clk) disable iff (!rstn)
    (tok_valid_o && !tok_o.lit) |->
      (tok_o.len >= `LZ_LEN_MIN && tok_o.len <= `LZ_LEN_MAX))
    else begin
      $error("pair length out of range");
      fail_cnt++;
    end

endmodule
